//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_dpa -o tb_dpa \
    && ./obj_dir/tb_dpa | tee sim.log \
    && grep -qx "TEST PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src.f
src/dpa_pkg.sv
src/pix_if.sv
src/clock_keeper.sv
src/overlay_renderer.sv
src/album_ctrl.sv
src/dpa_top.sv
tests/tb_mem_models.sv
tests/tb_dpa.sv

//--- src/album_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module album_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    output dpa_pkg::im_addr_t    im_a,
    input  dpa_pkg::pixel_t      im_q,
    output dpa_pkg::pixel_t      im_d,
    output logic                 im_wen,
    pix_if.controller            pix,
    output logic                 load,
    output dpa_pkg::clock_time_t load_time,
    input  logic                 sec_tick,
    output logic                 start
);
    import dpa_pkg::*;

    ctrl_state_t state;
    im_addr_t    addr_r;      // header read address
    im_addr_t    fb_base;
    logic        drawing;     // between start and done

    // im_q lags im_a by one cycle
    assign load = (state == st_load_fb);

    assign im_a = (state == st_run) ? fb_base + im_addr_t'(pix.offset) : addr_r;
    assign im_d = pix.data;
    assign im_wen = !((state == st_run) && pix.valid);   // low = write

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_load_time;
            addr_r <= hdr_time_addr;
            start <= 1'b0;
            drawing <= 1'b0;
        end else begin
            start <= load || sec_tick;   // redraw after load and every tick
            if (start) begin
                drawing <= 1'b1;
            end else if (pix.done) begin
                drawing <= 1'b0;
            end
            case (state)
                st_load_time: begin
                    if (addr_r == hdr_fb_addr) begin
                        state <= st_load_fb;
                    end else begin
                        addr_r <= hdr_fb_addr;
                    end
                end
                st_load_fb: begin
                    state <= st_run;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_load_time) && (addr_r == hdr_fb_addr)) begin
            load_time <= im_q;               // word 0 on the bus now
        end
        if (state == st_load_fb) begin
            fb_base <= im_q[19:0];
        end
    end

    a_no_write_before_base: assert property (
        @(posedge clk) disable iff (reset)
        pix.valid |-> (state == st_run)
    );

    // a frame must finish within one second
    a_tick_outside_draw: assert property (
        @(posedge clk) disable iff (reset)
        sec_tick |-> !(drawing || start)
    );

endmodule

`default_nettype wire

//--- src/clock_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module clock_keeper #(
    parameter int cycles_per_sec = 1000000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  dpa_pkg::clock_time_t load_time,
    output dpa_pkg::clock_time_t now,
    output logic                 sec_tick
);
    import dpa_pkg::*;

    localparam int div_w = $clog2(cycles_per_sec);
    localparam logic [div_w-1:0] div_last = div_w'(cycles_per_sec - 1);

    logic [div_w-1:0] div_cnt;
    logic             running;    // set once a time has been loaded
    time_field_t      hh;
    time_field_t      mm;
    time_field_t      ss;
    clock_time_t      next_time;

    assign {hh, mm, ss} = now;
    assign sec_tick = running && (div_cnt == div_last);

    // one second later, with rollover at 23:59:59
    always_comb begin
        next_time = now;
        if (ss == 8'd59) begin
            next_time[7:0] = 8'd0;
            if (mm == 8'd59) begin
                next_time[15:8] = 8'd0;
                if (hh == 8'd23) begin
                    next_time[23:16] = 8'd0;
                end else begin
                    next_time[23:16] = hh + 8'd1;
                end
            end else begin
                next_time[15:8] = mm + 8'd1;
            end
        end else begin
            next_time[7:0] = ss + 8'd1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            running <= 1'b0;
            now <= '0;
        end else if (load) begin
            div_cnt <= '0;        // first tick cycles_per_sec after load
            running <= 1'b1;
            now <= load_time;
        end else if (running) begin
            if (sec_tick) begin
                div_cnt <= '0;
                now <= next_time;
            end else begin
                div_cnt <= div_cnt + div_w'(1);
            end
        end
    end

    a_time_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (hh < 8'd24) && (mm < 8'd60) && (ss < 8'd60)
    );

endmodule

`default_nettype wire

//--- src/dpa_pkg.sv
`default_nettype none

package dpa_pkg;

    typedef logic [19:0] im_addr_t;     // image-memory address
    typedef logic [23:0] pixel_t;       // rgb, 8 bits each
    typedef logic [8:0]  cr_addr_t;     // character-ROM address
    typedef logic [12:0] glyph_row_t;   // bit 12 is leftmost pixel
    typedef logic [7:0]  time_field_t;  // binary hour, minute or second
    typedef logic [23:0] clock_time_t;  // {hour, minute, second}
    typedef logic [3:0]  digit_t;       // decimal digit or glyph code
    typedef logic [15:0] fb_offset_t;   // offset inside frame buffer

    // frame-buffer geometry
    localparam int fb_width = 256;
    localparam fb_offset_t clk_base_offset = 16'd59544;  // row 232, column 152

    // glyph layout of the overlay
    localparam int glyph_width = 13;
    localparam int glyph_rows = 24;
    localparam int num_chars = 8;        // hh:mm:ss
    localparam digit_t colon_code = 4'd10;

    // header words in image memory
    localparam im_addr_t hdr_time_addr = 20'd0;
    localparam im_addr_t hdr_fb_addr = 20'd1;

    localparam pixel_t white_pixel = 24'hff_ffff;

    typedef enum logic [1:0] {
        st_load_time,   // fetch start time word
        st_load_fb,     // fetch frame-buffer base
        st_run
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/dpa_top.sv
`timescale 1ns/1ps
`default_nettype none

module dpa_top #(
    parameter int cycles_per_sec = 1000000
) (
    input  logic                clk,
    input  logic                reset,
    output dpa_pkg::im_addr_t   im_a,
    input  dpa_pkg::pixel_t     im_q,
    output dpa_pkg::pixel_t     im_d,
    output logic                im_wen,
    output dpa_pkg::cr_addr_t   cr_a,
    input  dpa_pkg::glyph_row_t cr_q
);
    import dpa_pkg::*;

    clock_time_t now;
    clock_time_t load_time;
    logic        load;
    logic        sec_tick;
    logic        start;

    pix_if pix0 ();

    album_ctrl ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .im_a      (im_a),
        .im_q      (im_q),
        .im_d      (im_d),
        .im_wen    (im_wen),
        .pix       (pix0.controller),
        .load      (load),
        .load_time (load_time),
        .sec_tick  (sec_tick),
        .start     (start)
    );

    clock_keeper #(
        .cycles_per_sec (cycles_per_sec)
    ) keeper0 (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .load_time (load_time),
        .now       (now),
        .sec_tick  (sec_tick)
    );

    overlay_renderer render0 (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .now   (now),
        .cr_a  (cr_a),
        .cr_q  (cr_q),
        .pix   (pix0.renderer)
    );

endmodule

`default_nettype wire

//--- src/overlay_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_renderer (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  dpa_pkg::clock_time_t now,
    output dpa_pkg::cr_addr_t   cr_a,
    input  dpa_pkg::glyph_row_t cr_q,
    pix_if.renderer             pix
);
    import dpa_pkg::*;

    clock_time_t shown;       // time latched at start
    logic [7:0]  hh_d;
    logic [7:0]  mm_d;
    logic [7:0]  ss_d;
    digit_t      char_code;
    logic        busy;
    logic [2:0]  char_cnt;
    logic [4:0]  row_cnt;
    logic [3:0]  col_cnt;     // 0 is the ROM fetch cycle
    glyph_row_t  shift_r;
    glyph_row_t  cur_row;
    logic        last_write;
    logic        done_r;

    // binary field to {tens, ones}
    function automatic logic [7:0] to_digits(input time_field_t f);
        digit_t      tens;
        time_field_t rest;
        tens = '0;
        rest = f;
        for (int i = 0; i < 9; i++) begin
            if (rest >= 8'd10) begin
                rest = rest - 8'd10;
                tens = tens + 4'd1;
            end
        end
        return {tens, rest[3:0]};
    endfunction

    assign hh_d = to_digits(shown[23:16]);
    assign mm_d = to_digits(shown[15:8]);
    assign ss_d = to_digits(shown[7:0]);

    always_comb begin
        case (char_cnt)
            3'd0: char_code = hh_d[7:4];
            3'd1: char_code = hh_d[3:0];
            3'd3: char_code = mm_d[7:4];
            3'd4: char_code = mm_d[3:0];
            3'd6: char_code = ss_d[7:4];
            3'd7: char_code = ss_d[3:0];
            default: char_code = colon_code;   // positions 2 and 5
        endcase
    end

    // address held for the whole row, so either ROM latency works
    assign cr_a = cr_addr_t'(char_code) * cr_addr_t'(glyph_rows) + cr_addr_t'(row_cnt);

    assign cur_row = (col_cnt == 4'd1) ? cr_q : shift_r;

    assign last_write = busy && (char_cnt == 3'(num_chars - 1))
                        && (row_cnt == 5'(glyph_rows - 1))
                        && (col_cnt == 4'(glyph_width));

    assign pix.valid = busy && (col_cnt != 4'd0);
    assign pix.offset = clk_base_offset
                        + fb_offset_t'(char_cnt) * fb_offset_t'(glyph_width)
                        + fb_offset_t'(row_cnt) * fb_offset_t'(fb_width)
                        + fb_offset_t'(col_cnt) - 16'd1;
    assign pix.data = cur_row[12] ? white_pixel : '0;
    assign pix.done = done_r;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            char_cnt <= '0;
            row_cnt <= '0;
            col_cnt <= '0;
            done_r <= 1'b0;
        end else begin
            done_r <= last_write;
            if (start) begin
                busy <= 1'b1;
                char_cnt <= '0;
                row_cnt <= '0;
                col_cnt <= '0;
            end else if (busy) begin
                if (col_cnt == 4'(glyph_width)) begin
                    col_cnt <= '0;
                    if (row_cnt == 5'(glyph_rows - 1)) begin
                        row_cnt <= '0;
                        if (char_cnt == 3'(num_chars - 1)) begin
                            busy <= 1'b0;
                        end else begin
                            char_cnt <= char_cnt + 3'd1;
                        end
                    end else begin
                        row_cnt <= row_cnt + 5'd1;
                    end
                end else begin
                    col_cnt <= col_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shown <= now;
        end
        if (pix.valid) begin
            shift_r <= cur_row << 1;   // next pixel to bit 12
        end
    end

    // controller must wait for done before the next frame
    a_no_start_mid_frame: assert property (
        @(posedge clk) disable iff (reset)
        start |-> !busy
    );

endmodule

`default_nettype wire

//--- src/pix_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pix_if;
    import dpa_pkg::*;

    logic       valid;
    fb_offset_t offset;   // relative to frame-buffer base
    pixel_t     data;
    logic       done;     // one cycle after last write of a frame

    modport renderer (
        output valid,
        output offset,
        output data,
        output done
    );

    modport controller (
        input valid,
        input offset,
        input data,
        input done
    );

endinterface

`default_nettype wire

//--- tests/tb_dpa.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dpa;
    import dpa_pkg::*;

    localparam int cycles_per_sec = 4000;
    localparam int frame_writes = 2496;               // 8 chars x 24 rows x 13 pixels
    localparam int cycle_limit = 10 * cycles_per_sec; // two sessions of about 7000 cycles
    localparam int quiet_cycles = 100;

    logic       clk;
    logic       reset;
    im_addr_t   im_a;
    pixel_t     im_q;
    pixel_t     im_d;
    logic       im_wen;
    cr_addr_t   cr_a;
    glyph_row_t cr_q;
    pixel_t     hdr_time;
    pixel_t     hdr_base;
    glyph_row_t glyph_rom [0:511];
    logic       log_valid;
    im_addr_t   log_addr;
    pixel_t     log_data;

    im_addr_t exp_addr [$];
    pixel_t   exp_data [$];
    im_addr_t cur_base;
    logic     frame_started;
    int       first_write_cycle;
    int       first_frame_cycle;
    int       frame_write_cnt;
    int       total_writes;
    int       cycle_cnt;
    int       check_errs;
    int       window_errs;
    int       errs_before;
    int       tests_run;
    int       tests_failed;

    dpa_top #(
        .cycles_per_sec (cycles_per_sec)
    ) dut0 (
        .clk    (clk),
        .reset  (reset),
        .im_a   (im_a),
        .im_q   (im_q),
        .im_d   (im_d),
        .im_wen (im_wen),
        .cr_a   (cr_a),
        .cr_q   (cr_q)
    );

    image_mem_model mem0 (
        .clk       (clk),
        .im_a      (im_a),
        .im_d      (im_d),
        .im_wen    (im_wen),
        .im_q      (im_q),
        .hdr_time  (hdr_time),
        .hdr_base  (hdr_base),
        .log_valid (log_valid),
        .log_addr  (log_addr),
        .log_data  (log_data)
    );

    char_rom_model rom0 (
        .clk  (clk),
        .cr_a (cr_a),
        .rows (glyph_rom),
        .cr_q (cr_q)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: no end of test after %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // all writes of one frame in drawing order
    function automatic void expected_frame(input int hh, input int mm, input int ss,
                                           input im_addr_t base);
        int         code [0:7];
        int         off;
        glyph_row_t bits;
        code[0] = hh / 10;
        code[1] = hh % 10;
        code[2] = 10;        // colon glyph
        code[3] = mm / 10;
        code[4] = mm % 10;
        code[5] = 10;
        code[6] = ss / 10;
        code[7] = ss % 10;
        for (int c = 0; c < 8; c++) begin
            for (int r = 0; r < 24; r++) begin
                bits = glyph_rom[9'(code[3'(c)] * 24 + r)];
                for (int k = 0; k < 13; k++) begin
                    off = 59544 + c * 13 + r * 256 + k;   // row 232, column 152
                    exp_addr.push_back(base + im_addr_t'(off));
                    exp_data.push_back(bits[4'(12 - k)] ? 24'hff_ffff : 24'h00_0000);
                end
            end
        end
    endfunction

    always @(negedge clk) begin : compare_writes
        im_addr_t want_a;
        pixel_t   want_d;
        im_addr_t off;
        if (log_valid === 1'b1) begin
            frame_write_cnt = frame_write_cnt + 1;
            total_writes = total_writes + 1;
            if (!frame_started) begin
                frame_started = 1'b1;
                first_write_cycle = cycle_cnt;
            end
            off = log_addr - cur_base;
            assert (off >= 20'd59544 && off <= 20'd65535 && off[7:0] >= 8'd152) else begin
                $display("write to %h falls outside the overlay window", log_addr);
                window_errs++;
            end
            assert (log_data == 24'h00_0000 || log_data == 24'hff_ffff) else begin
                $display("CHECK FAILED: im_d = %h, expected 000000 or ffffff", log_data);
                window_errs++;
            end
            assert (exp_addr.size() != 0) else begin
                $display("unexpected write to %h while no frame was due", log_addr);
                check_errs++;
            end
            if (exp_addr.size() != 0) begin
                want_a = exp_addr.pop_front();
                want_d = exp_data.pop_front();
                assert (log_addr == want_a) else begin
                    $display("CHECK FAILED: im_a = %h, expected %h", log_addr, want_a);
                    check_errs++;
                end
                assert (log_data == want_d) else begin
                    $display("CHECK FAILED: im_d = %h, expected %h at %h",
                             log_data, want_d, want_a);
                    check_errs++;
                end
            end
        end
    end

    task automatic power_up(input int hh, input int mm, input int ss);
        cur_base = im_addr_t'(2 + $urandom % 983038);   // clear of header, no wrap
        hdr_time = {8'(hh), 8'(mm), 8'(ss)};
        hdr_base = {4'h0, cur_base};
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic check_header_reads;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            assert (im_wen === 1'b1) else begin
                $display("CHECK FAILED: im_wen = %h, expected 1", im_wen);
                check_errs++;
            end
            if (i < 2) begin
                assert (im_a === im_addr_t'(i)) else begin
                    $display("CHECK FAILED: im_a = %h, expected %h", im_a, im_addr_t'(i));
                    check_errs++;
                end
            end
        end
    endtask

    task automatic run_frame(input int hh, input int mm, input int ss);
        frame_started = 1'b0;
        frame_write_cnt = 0;
        expected_frame(hh, mm, ss, cur_base);
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (quiet_cycles) @(posedge clk);   // extra writes show up here
        #1;
        assert (frame_write_cnt == frame_writes) else begin
            $display("CHECK FAILED: frame write count = %h, expected %h",
                     frame_write_cnt, frame_writes);
            check_errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errs);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        hdr_time = '0;
        hdr_base = '0;
        cur_base = '0;
        frame_started = 1'b0;
        first_write_cycle = 0;
        first_frame_cycle = 0;
        frame_write_cnt = 0;
        total_writes = 0;
        cycle_cnt = 0;
        check_errs = 0;
        window_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(24));
        for (int i = 0; i < 512; i++) begin
            glyph_rom[i] = glyph_row_t'($urandom);
        end

        power_up(12, 34, 56);
        errs_before = check_errs;
        check_header_reads();
        report_test("header reads after reset", check_errs - errs_before);

        errs_before = check_errs;
        run_frame(12, 34, 56);
        first_frame_cycle = first_write_cycle;
        report_test("first frame 12:34:56", check_errs - errs_before);

        errs_before = check_errs;
        run_frame(12, 34, 57);
        assert (first_write_cycle - first_frame_cycle == cycles_per_sec) else begin
            $display("CHECK FAILED: frame interval = %h, expected %h",
                     first_write_cycle - first_frame_cycle, cycles_per_sec);
            check_errs++;
        end
        report_test("frame one second later", check_errs - errs_before);

        errs_before = check_errs;
        power_up(23, 59, 59);
        check_header_reads();
        run_frame(23, 59, 59);
        run_frame(0, 0, 0);
        report_test("rollover to 00:00:00", check_errs - errs_before);

        assert (total_writes == 4 * frame_writes) else begin
            $display("CHECK FAILED: total writes = %h, expected %h",
                     total_writes, 4 * frame_writes);
            window_errs++;
        end
        report_test("window and colour of all writes", window_errs);

        $display("%0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, check_errs + window_errs);
        if (tests_failed == 0 && check_errs + window_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_mem_models.sv
`timescale 1ns/1ps
`default_nettype none

// image memory with one-cycle read latency
module image_mem_model (
    input  logic              clk,
    input  dpa_pkg::im_addr_t im_a,
    input  dpa_pkg::pixel_t   im_d,
    input  logic              im_wen,
    output dpa_pkg::pixel_t   im_q,
    input  dpa_pkg::pixel_t   hdr_time,   // header word 0
    input  dpa_pkg::pixel_t   hdr_base,   // header word 1
    output logic              log_valid,  // one record per accepted write
    output dpa_pkg::im_addr_t log_addr,
    output dpa_pkg::pixel_t   log_data
);
    import dpa_pkg::*;

    pixel_t store [im_addr_t];

    initial begin
        im_q = '0;
        log_valid = 1'b0;
        log_addr = '0;
        log_data = '0;
    end

    always @(posedge clk) begin
        if (im_a == hdr_time_addr) begin
            im_q <= hdr_time;
        end else if (im_a == hdr_fb_addr) begin
            im_q <= hdr_base;
        end else if (store.exists(im_a)) begin
            im_q <= store[im_a];
        end else begin
            im_q <= '0;
        end
        log_valid <= !im_wen;
        if (!im_wen) begin
            store[im_a] = im_d;   // read above still sees the old word
            log_addr <= im_a;
            log_data <= im_d;
        end
    end

endmodule

// glyph ROM, registered output
module char_rom_model (
    input  logic                clk,
    input  dpa_pkg::cr_addr_t   cr_a,
    input  dpa_pkg::glyph_row_t rows [0:511],
    output dpa_pkg::glyph_row_t cr_q
);
    initial begin
        cr_q = '0;
    end

    always @(posedge clk) begin
        cr_q <= rows[cr_a];
    end

endmodule

`default_nettype wire
